// ==== Makefile ====
# Verilator build and run for the rv_core testbench

VERILATOR ?= verilator
TOP       ?= rv_core_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FLIST     ?= flist.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)
CASES := test/core_cases.txt

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN) $(CASES)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/rv_pkg.sv ====
package rv_pkg;

    // datapath word, also used for instructions
    typedef logic [31:0] word_t;
    // register file index
    typedef logic [4:0] reg_idx_t;

    // base opcodes decoded by the core
    typedef enum logic [6:0] {
        R_OP   = 7'b0110011,
        I_OP   = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // alu functions, PASS_B forwards the second operand (lui)
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B
    } alu_op_e;

    // register write source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK
    } wb_sel_e;

    // branch funct3 codes
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    // shift right, bit30 picks arithmetic
    localparam logic [2:0] F3_SR  = 3'b101;

    // control bits produced in decode, all zero is a bubble
    typedef struct packed {
        logic    branch;
        logic    jump;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        logic    pc_base;
        wb_sel_e wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    pc;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        logic [2:0] funct3;
        logic     bit30;
        reg_idx_t rd;
        opcode_e  opcode;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;
        logic     zero;
        word_t    store_data;
        word_t    target;
        word_t    link;
        logic [2:0] funct3;
        reg_idx_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic     reg_write;
        wb_sel_e  wb_sel;
        word_t    alu_result;
        word_t    load_data;
        word_t    link;
        reg_idx_t rd;
    } mem_wb_t;

endpackage

// ==== flist.f ====
common/rv_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/execute_unit.sv
hdl/writeback_unit.sv
hdl/rv_core.sv
test/rv_core_tb.sv

// ==== hdl/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
    input  logic              CLK,
    input  logic              RESET_N,
    input  logic              clear,
    input  rv_pkg::if_id_t    if_id,
    input  rv_pkg::word_t     rs1_val,
    input  rv_pkg::word_t     rs2_val,
    output rv_pkg::reg_idx_t  rs1_idx,
    output rv_pkg::reg_idx_t  rs2_idx,
    output rv_pkg::id_ex_t    id_ex
);

    rv_pkg::opcode_e opcode;
    rv_pkg::ctrl_t   ctrl;
    rv_pkg::word_t   imm;
    rv_pkg::word_t   ins;

    assign ins     = if_id.instr;
    assign opcode  = rv_pkg::opcode_e'(ins[6:0]);
    // register file is read combinationally
    assign rs1_idx = ins[19:15];
    assign rs2_idx = ins[24:20];

    // main control
    always_comb begin
        ctrl = '0;
        if (if_id.valid) begin
            case (opcode)
                rv_pkg::R_OP: ctrl.reg_write = 1'b1;
                rv_pkg::I_OP: begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                end
                rv_pkg::LOAD: begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.mem_read    = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.wb_sel      = rv_pkg::WB_MEM;
                end
                rv_pkg::STORE: begin
                    ctrl.mem_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                end
                // compare via subtract, zero flag decides
                rv_pkg::BRANCH: ctrl.branch = 1'b1;
                rv_pkg::JAL: begin
                    ctrl.jump      = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = rv_pkg::WB_LINK;
                end
                rv_pkg::LUI: begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                end
                // pc replaces rs1 as first operand
                rv_pkg::AUIPC: begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.pc_base     = 1'b1;
                end
                default: ctrl = '0;
            endcase
        end
    end

    // immediate formats
    always_comb begin
        case (opcode)
            rv_pkg::I_OP,
            rv_pkg::LOAD:   imm = {{20{ins[31]}}, ins[31:20]};
            rv_pkg::STORE:  imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            rv_pkg::BRANCH: imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            rv_pkg::LUI,
            rv_pkg::AUIPC:  imm = {ins[31:12], 12'b0};
            rv_pkg::JAL:    imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            default:        imm = '0;
        endcase
    end

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            id_ex <= '0;
        end else if (clear) begin
            id_ex <= '0;
        end else begin
            id_ex.ctrl    <= ctrl;
            id_ex.pc      <= if_id.pc;
            id_ex.rs1_val <= rs1_val;
            id_ex.rs2_val <= rs2_val;
            id_ex.imm     <= imm;
            id_ex.funct3  <= ins[14:12];
            id_ex.bit30   <= ins[30];
            id_ex.rd      <= ins[11:7];
            id_ex.opcode  <= opcode;
        end
    end

endmodule

// ==== hdl/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit #(
    parameter int ADDR_SIZE = 10
) (
    input  logic             CLK,
    input  logic             RESET_N,
    input  logic             clear,
    input  rv_pkg::id_ex_t   id_ex,
    output rv_pkg::ex_mem_t  ex_mem,
    output logic             redirect,
    output rv_pkg::word_t    redirect_target
);

    rv_pkg::alu_op_e      alu_op;
    rv_pkg::word_t        op_a;
    rv_pkg::word_t        op_b;
    rv_pkg::word_t        alu_result;
    logic [ADDR_SIZE-1:0] target_addr;
    logic [ADDR_SIZE-1:0] link_addr;

    // funct3 to alu op, alt selects sub / sra
    function automatic rv_pkg::alu_op_e f3_to_op(input logic [2:0] f3, input logic alt);
        rv_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv_pkg::SUB : rv_pkg::ADD;
            3'b001:  op = rv_pkg::SLL;
            3'b010:  op = rv_pkg::SLT;
            3'b011:  op = rv_pkg::SLTU;
            3'b100:  op = rv_pkg::XOR;
            3'b101:  op = alt ? rv_pkg::SRA : rv_pkg::SRL;
            3'b110:  op = rv_pkg::OR;
            default: op = rv_pkg::AND;
        endcase
        return op;
    endfunction

    // immediate forms have no subi, bit30 only matters for srai
    always_comb begin
        case (id_ex.opcode)
            rv_pkg::R_OP:   alu_op = f3_to_op(id_ex.funct3, id_ex.bit30);
            rv_pkg::I_OP:   alu_op = f3_to_op(id_ex.funct3,
                                              id_ex.bit30 && id_ex.funct3 == rv_pkg::F3_SR);
            rv_pkg::BRANCH: alu_op = rv_pkg::SUB;
            rv_pkg::LUI:    alu_op = rv_pkg::PASS_B;
            default:        alu_op = rv_pkg::ADD;
        endcase
    end

    assign op_a = id_ex.ctrl.pc_base ? id_ex.pc : id_ex.rs1_val;
    assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rs2_val;

    always_comb begin
        case (alu_op)
            rv_pkg::ADD:    alu_result = op_a + op_b;
            rv_pkg::SUB:    alu_result = op_a - op_b;
            rv_pkg::SLL:    alu_result = op_a << op_b[4:0];
            rv_pkg::SLT:    alu_result = {31'b0, ($signed(op_a) < $signed(op_b))};
            rv_pkg::SLTU:   alu_result = {31'b0, (op_a < op_b)};
            rv_pkg::XOR:    alu_result = op_a ^ op_b;
            rv_pkg::SRL:    alu_result = op_a >> op_b[4:0];
            rv_pkg::SRA:    alu_result = rv_pkg::word_t'($signed(op_a) >>> op_b[4:0]);
            rv_pkg::OR:     alu_result = op_a | op_b;
            rv_pkg::AND:    alu_result = op_a & op_b;
            default:        alu_result = op_b;
        endcase
    end

    // branch target and jal link live in the pc address space
    assign target_addr = id_ex.pc[ADDR_SIZE-1:0] + id_ex.imm[ADDR_SIZE-1:0];
    assign link_addr   = id_ex.pc[ADDR_SIZE-1:0] + ADDR_SIZE'(4);

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            ex_mem <= '0;
        end else if (clear) begin
            ex_mem <= '0;
        end else begin
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.alu_result <= alu_result;
            ex_mem.zero       <= (alu_result == '0);
            ex_mem.store_data <= id_ex.rs2_val;
            ex_mem.target     <= {{(32-ADDR_SIZE){1'b0}}, target_addr};
            ex_mem.link       <= {{(32-ADDR_SIZE){1'b0}}, link_addr};
            ex_mem.funct3     <= id_ex.funct3;
            ex_mem.rd         <= id_ex.rd;
        end
    end

    // resolved in the memory cycle, three younger instructions already in flight
    assign redirect = ex_mem.ctrl.jump ||
                      (ex_mem.ctrl.branch &&
                       ((ex_mem.funct3 == rv_pkg::F3_BNE && !ex_mem.zero) ||
                        (ex_mem.funct3 == rv_pkg::F3_BEQ && ex_mem.zero)));
    assign redirect_target = ex_mem.target;

    // decode never marks an instruction as both branch and jump
    redirect_src_a: assert property (@(posedge CLK) disable iff (!RESET_N)
        redirect |-> (ex_mem.ctrl.branch ^ ex_mem.ctrl.jump))
        else $error("execute: redirect without a single branch/jump source");

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
    parameter int ADDR_SIZE = 10
) (
    input  logic                 CLK,
    input  logic                 RESET_N,
    input  logic                 clear,
    input  logic                 redirect,
    input  rv_pkg::word_t        redirect_target,
    input  rv_pkg::word_t        instr,
    output logic [ADDR_SIZE-3:0] iaddr,
    output rv_pkg::if_id_t       if_id
);

    // byte address of the instruction on the rom port
    logic [ADDR_SIZE-1:0] pc;
    logic [ADDR_SIZE-1:0] next_pc;

    // taken branch or jal wins over pc + 4, upper target bits dropped
    assign next_pc = redirect ? redirect_target[ADDR_SIZE-1:0] : pc + ADDR_SIZE'(4);

    // rom is word addressed
    assign iaddr = pc[ADDR_SIZE-1:2];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc     <= '0;
            if_id  <= '0;
        end else if (clear) begin
            pc     <= '0;
            if_id  <= '0;
        end else begin
            pc           <= next_pc;
            // instruction arrives in the same cycle as iaddr
            if_id.valid  <= 1'b1;
            if_id.pc     <= {{(32-ADDR_SIZE){1'b0}}, pc};
            if_id.instr  <= instr;
        end
    end

    // targets come back from execute, so alignment relies on imm generation
    pc_aligned_a: assert property (@(posedge CLK) disable iff (!RESET_N)
        pc[1:0] == 2'b00)
        else $error("fetch: misaligned pc %h", pc);

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic             CLK,
    input  logic             RESET_N,
    input  rv_pkg::reg_idx_t rs1_idx,
    input  rv_pkg::reg_idx_t rs2_idx,
    input  logic             wr_en,
    input  rv_pkg::reg_idx_t wr_idx,
    input  rv_pkg::word_t    wr_data,
    output rv_pkg::word_t    rs1_val,
    output rv_pkg::word_t    rs2_val
);

    rv_pkg::word_t regs [32];

    // x0 never takes a write
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // same-cycle write is passed through to the reader
    assign rs1_val = (rs1_idx == '0) ? '0 :
                     (wr_en && wr_idx == rs1_idx) ? wr_data : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 :
                     (wr_en && wr_idx == rs2_idx) ? wr_data : regs[rs2_idx];

endmodule

// ==== hdl/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
    parameter int ADDR_SIZE = 10
) (
    input  logic                 CLK,
    input  logic                 RESET_N,
    input  logic                 clear,
    input  rv_pkg::word_t        instr,
    input  rv_pkg::word_t        load_data,
    output logic [ADDR_SIZE-3:0] iaddr,
    output logic [ADDR_SIZE-3:0] daddr,
    output rv_pkg::word_t        store_data,
    output logic                 mem_write,
    output logic                 mem_read
);

    // stage registers
    rv_pkg::if_id_t   if_id;
    rv_pkg::id_ex_t   id_ex;
    rv_pkg::ex_mem_t  ex_mem;

    // register file read side
    rv_pkg::reg_idx_t rs1_idx;
    rv_pkg::reg_idx_t rs2_idx;
    rv_pkg::word_t    rs1_val;
    rv_pkg::word_t    rs2_val;

    // register file write side, from writeback
    logic             wr_en;
    rv_pkg::reg_idx_t wr_idx;
    rv_pkg::word_t    wr_data;

    // pc redirect from the memory stage
    logic             redirect;
    rv_pkg::word_t    redirect_target;

    fetch_unit #(.ADDR_SIZE(ADDR_SIZE)) fetch_i (
        .CLK             (CLK),
        .RESET_N         (RESET_N),
        .clear           (clear),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .instr           (instr),
        .iaddr           (iaddr),
        .if_id           (if_id)
    );

    decode_unit decode_i (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .clear   (clear),
        .if_id   (if_id),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .id_ex   (id_ex)
    );

    reg_file reg_file_i (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    execute_unit #(.ADDR_SIZE(ADDR_SIZE)) execute_i (
        .CLK             (CLK),
        .RESET_N         (RESET_N),
        .clear           (clear),
        .id_ex           (id_ex),
        .ex_mem          (ex_mem),
        .redirect        (redirect),
        .redirect_target (redirect_target)
    );

    writeback_unit writeback_i (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .clear     (clear),
        .ex_mem    (ex_mem),
        .load_data (load_data),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data)
    );

    // data port driven straight from ex_mem during the memory cycle
    assign daddr      = ex_mem.alu_result[ADDR_SIZE-1:2];
    assign store_data = ex_mem.store_data;
    assign mem_write  = ex_mem.ctrl.mem_write;
    assign mem_read   = ex_mem.ctrl.mem_read;

    // one data access per cycle at most
    mem_strobe_a: assert property (@(posedge CLK) disable iff (!RESET_N)
        !(mem_write && mem_read))
        else $error("core: mem_write and mem_read both high");

endmodule

// ==== hdl/writeback_unit.sv ====
`timescale 1ns/1ps

module writeback_unit (
    input  logic             CLK,
    input  logic             RESET_N,
    input  logic             clear,
    input  rv_pkg::ex_mem_t  ex_mem,
    input  rv_pkg::word_t    load_data,
    output logic             wr_en,
    output rv_pkg::reg_idx_t wr_idx,
    output rv_pkg::word_t    wr_data
);

    rv_pkg::mem_wb_t mem_wb;

    // load data is sampled at the end of the memory cycle
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            mem_wb <= '0;
        end else if (clear) begin
            mem_wb <= '0;
        end else begin
            mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
            mem_wb.wb_sel     <= ex_mem.ctrl.wb_sel;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.load_data  <= load_data;
            mem_wb.link       <= ex_mem.link;
            mem_wb.rd         <= ex_mem.rd;
        end
    end

    assign wr_en  = mem_wb.reg_write;
    assign wr_idx = mem_wb.rd;

    always_comb begin
        case (mem_wb.wb_sel)
            rv_pkg::WB_MEM:  wr_data = mem_wb.load_data;
            rv_pkg::WB_LINK: wr_data = mem_wb.link;
            default:         wr_data = mem_wb.alu_result;
        endcase
    end

endmodule

// ==== test/core_cases.txt ====
# I: eight instruction words in hex, loaded from rom word 0 upward
# T: test name, expected store word address (hex), expected store value (hex)
I 20000093 FF800113 00300193 00000013 00000013 003102B3 40310333 003113B3
I 00312433 003134B3 00314533 003155B3 40315633 003166B3 00317733 0050A023
I 0060A223 0070A423 0080A623 0090A823 00A0AA23 00B0AC23 00C0AE23 02D0A023
I 02E0A223 06410793 0F014813 FFF12893 00419913 40215993 12345A37 00001A97
I 02F0A423 0300A623 0310A823 0320AA23 0330AC23 0340AE23 0550A023 0540A223
I 00000013 00000013 0440AB03 00000013 00000013 001B0B13 00000013 00000013
I 0560A423 05500B93 00000013 00000013 001B8C13 00000013 00000013 0580A623
I 00318A63 0430A823 0430AA23 0430AC23 0430AE23 0630A023 00310A63 0630A223
I 0630A423 0630A623 0630A823 00311A63 0630AC23 0630AE23 0830A023 0830A223
I 0830A423 00319A63 0830A623 0830A823 0830AA23 0830AC23 01400CEF 0830AE23
I 0A30A023 0A30A223 0A30A423 0B90A623 0000006F 00000000 00000000 00000000
T add_rr 80 FFFFFFFB
T sub_rr 81 FFFFFFF5
T sll_rr 82 FFFFFFC0
T slt_rr 83 00000001
T sltu_rr 84 00000000
T xor_rr 85 FFFFFFFB
T srl_rr 86 1FFFFFFF
T sra_rr 87 FFFFFFFF
T or_rr 88 FFFFFFFB
T and_rr 89 00000000
T addi 8A 0000005C
T xori 8B FFFFFF08
T slti 8C 00000001
T slli 8D 00000030
T srai 8E FFFFFFFE
T lui 8F 12345000
T auipc 90 0000107C
T store_word 91 12345000
T load_add_one 92 12345001
T write_through 93 00000056
T beq_taken_shadow0 94 00000003
T beq_taken_shadow1 95 00000003
T beq_taken_shadow2 96 00000003
T beq_taken_target 98 00000003
T beq_not_taken0 99 00000003
T beq_not_taken1 9A 00000003
T beq_not_taken2 9B 00000003
T beq_not_taken3 9C 00000003
T bne_taken_shadow0 9E 00000003
T bne_taken_shadow1 9F 00000003
T bne_taken_shadow2 A0 00000003
T bne_taken_target A2 00000003
T bne_not_taken0 A3 00000003
T bne_not_taken1 A4 00000003
T bne_not_taken2 A5 00000003
T bne_not_taken3 A6 00000003
T jal_shadow0 A7 00000003
T jal_shadow1 A8 00000003
T jal_shadow2 A9 00000003
T jal_link AB 0000013C

// ==== test/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

    localparam int ADDR_SIZE    = 10;
    localparam int WORDS        = 2 ** (ADDR_SIZE - 2);
    localparam int RESET_CYCLES = 8;
    localparam int SLACK_CYCLES = 16;

    logic                 CLK;
    logic                 RESET_N;
    logic                 clear;
    rv_pkg::word_t        instr;
    rv_pkg::word_t        load_data;
    logic [ADDR_SIZE-3:0] iaddr;
    logic [ADDR_SIZE-3:0] daddr;
    rv_pkg::word_t        store_data;
    logic                 mem_write;
    logic                 mem_read;

    // instruction rom and data ram, both word addressed
    rv_pkg::word_t rom [WORDS];
    rv_pkg::word_t ram [WORDS];
    // words the program has stored, loads may only read these
    logic          written [WORDS];

    // expected stores in program order
    string                exp_name [$];
    logic [ADDR_SIZE-3:0] exp_addr [$];
    rv_pkg::word_t        exp_val  [$];

    int n_words;
    int cycles;
    int passes;
    int fails;
    int limit;

    rv_core #(.ADDR_SIZE(ADDR_SIZE)) rv_core_i (
        .CLK        (CLK),
        .RESET_N    (RESET_N),
        .clear      (clear),
        .instr      (instr),
        .load_data  (load_data),
        .iaddr      (iaddr),
        .daddr      (daddr),
        .store_data (store_data),
        .mem_write  (mem_write),
        .mem_read   (mem_read)
    );

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;

    // both memories answer in zero cycles
    assign instr     = rom[iaddr];
    // ram drives load data only on a read
    assign load_data = mem_read ? ram[daddr] : '0;

    always @(posedge CLK) begin
        if (mem_write) begin
            ram[daddr]     <= store_data;
            written[daddr] <= 1'b1;
        end
    end

    // fill ram with noise, rom with zero words (bubbles)
    task automatic fill_memories();
        void'($urandom(32'h215b8878));
        for (int i = 0; i < WORDS; i++) begin
            rom[i[ADDR_SIZE-3:0]]     = '0;
            ram[i[ADDR_SIZE-3:0]]     <= $urandom ^ i;
            written[i[ADDR_SIZE-3:0]] <= 1'b0;
        end
    endtask

    // I lines carry eight rom words, T lines one expected store
    task automatic read_cases();
        int            fd;
        int            code;
        string         tag;
        string         rest;
        string         nm;
        rv_pkg::word_t a;
        rv_pkg::word_t v;
        fd = $fopen("test/core_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/core_cases.txt");
            fails++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "I") begin
                for (int k = 0; k < 8; k++) begin
                    code = $fscanf(fd, "%h", v);
                    rom[n_words[ADDR_SIZE-3:0]] = v;
                    n_words++;
                end
            end else if (tag == "T") begin
                code = $fscanf(fd, "%s %h %h", nm, a, v);
                exp_name.push_back(nm);
                exp_addr.push_back(a[ADDR_SIZE-3:0]);
                exp_val.push_back(v);
            end else begin
                $display("unknown line tag %s in case file", tag);
                fails++;
            end
        end
        $fclose(fd);
    endtask

    // sample the data port mid-cycle, away from both edges
    always @(negedge CLK) begin
        logic ok;
        if (RESET_N && mem_read) begin
            assert (written[daddr]) else begin
                $display("load from data word %h that no store has written", daddr);
                fails++;
            end
        end
        if (RESET_N && mem_write) begin
            if (exp_name.size() == 0) begin
                $display("unexpected store of %h to word %h", store_data, daddr);
                fails++;
            end else begin
                ok = (daddr == exp_addr[0]) && (store_data == exp_val[0]);
                assert (ok) else begin
                    $display("error %s: expected addr %h data %h, actual addr %h data %h",
                             exp_name[0], exp_addr[0], exp_val[0], daddr, store_data);
                    fails++;
                end
                if (ok) begin
                    $display("pass %s", exp_name[0]);
                    passes++;
                end
                void'(exp_name.pop_front());
                void'(exp_addr.pop_front());
                void'(exp_val.pop_front());
            end
        end
    end

    initial begin
        RESET_N = 1'b0;
        clear   = 1'b0;
        n_words = 0;
        cycles  = 0;
        passes  = 0;
        fails   = 0;
        fill_memories();
        read_cases();
        limit = n_words + SLACK_CYCLES + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        RESET_N = 1'b1;
        clear   = 1'b0;

        while (exp_name.size() != 0 && cycles < limit) begin
            @(posedge CLK);
            cycles++;
        end
        if (exp_name.size() != 0) begin
            $display("timeout after %0d cycles, %0d expected stores missing",
                     cycles, exp_name.size());
            fails++;
        end
        // a few more cycles to catch stray stores
        repeat (4) @(posedge CLK);

        $display("tests passed %0d failed %0d", passes, fails);
        if (fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
